//--- project.f
rtl/umi_reg_pkg.sv
rtl/umi_req_dispatch.sv
rtl/umi_regbank.sv
rtl/umi_resp_merge.sv
rtl/umi_reg_subsys.sv
bench/umi_reg_subsys_chk.sv
bench/umi_reg_subsys_tb.sv

//--- Makefile
SIM   ?= verilator
FLAGS ?= --binary --timing --assert -j 0
TOP   ?= umi_reg_subsys_tb
FLIST ?= project.f
OBJ   ?= obj_dir
LOG   ?= sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(OBJ) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ) $(LOG)

//--- bench/umi_reg_subsys_tb.sv
`timescale 1ns/1ps

module umi_reg_subsys_tb;

   import umi_reg_pkg::*;

   localparam AW     = 32;
   localparam DW     = 32;
   localparam NBANKS = 4;
   localparam REGS   = 8;
   localparam UW     = ADDR_LSB + 2*AW + DW;
   localparam REGW   = $clog2(REGS);
   localparam IDXW   = $clog2(NBANKS*REGS);  // bank plus register bits

   localparam int            PERIOD      = 40;
   localparam int            HOLD        = 2;   // drive delay after rising edge
   localparam int            RST_CYC     = 8;
   localparam logic [31:0]   SEED        = 32'h96af_29ac;
   localparam logic [AW-1:0] TAG_BASE    = 32'h4000_0000;  // srcaddr tags start here
   localparam int            TAGW        = 8;
   localparam int            MAX_TAGS    = 1 << TAGW;
   localparam int            WR_ROUNDS   = 5;
   localparam int            WR_BATCH    = 8;
   localparam int            CONC_REPS   = 2;
   localparam int            BP_OPS      = 60;
   localparam int            DRAIN_LIMIT = 2000;
   localparam int            TOTAL_OPS   = NBANKS*REGS + 2*WR_ROUNDS*WR_BATCH + 1
                                           + CONC_REPS*NBANKS + BP_OPS;

   logic          clk;
   logic          nreset;
   logic          in_valid;
   logic [UW-1:0] in_packet;
   logic          in_ready;
   logic          out_valid;
   logic [UW-1:0] out_packet;
   logic          out_ready;

   integer          seed;
   integer          rdy_seed;       // separate stream for out_ready toggling
   logic            bp_on;          // random back-pressure enable
   logic [DW-1:0]   model [NBANKS*REGS];
   logic [DW-1:0]   exp_data [MAX_TAGS];
   logic [3:0]      exp_size [MAX_TAGS];
   logic            pending [MAX_TAGS];
   logic [TAGW-1:0] next_tag;
   int              outstanding;    // reads sent, response not yet seen
   int              reads_sent;
   int              resp_count;
   int              errors;
   int              tests_failed;

   initial clk = 1'b0;
   always #(PERIOD/2) clk = ~clk;

   umi_reg_subsys #(
      .AW(AW), .DW(DW), .NBANKS(NBANKS), .REGS(REGS)
   ) umi_reg_subsys_i (
      .clk        (clk),
      .nreset     (nreset),
      .in_valid   (in_valid),
      .in_packet  (in_packet),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready)
   );

   bind umi_reg_subsys umi_reg_subsys_chk #(.UW(UW)) u_chk (
      .clk        (clk),
      .nreset     (nreset),
      .in_ready   (in_ready),
      .out_valid  (out_valid),
      .out_packet (out_packet),
      .out_ready  (out_ready)
   );

   //####################################################################
   // helpers
   //####################################################################

   function automatic int total_fails();
      return errors + int'(umi_reg_subsys_i.u_chk.fails);
   endfunction

   task automatic report_mismatch(input string sig, input logic [DW-1:0] got,
                                  input logic [DW-1:0] exp);
      $display("Fail %0t %s got %h expected %h", $time, sig, got, exp);
      errors++;
   endtask

   task automatic report_problem(input string what);
      $display("Error at %0t: %s", $time, what);
      errors++;
   endtask

   function automatic logic [UW-1:0] make_packet(input umi_cmd_t cmd, input logic [3:0] size,
      input logic [AW-1:0] dst, input logic [AW-1:0] src, input logic [DW-1:0] data);
      logic [UW-1:0] p;
      p                        = '0;
      p[CMD_LSB +: CMD_W]      = cmd;
      p[SIZE_LSB +: SIZE_W]    = size;
      p[ADDR_LSB +: AW]        = dst;
      p[ADDR_LSB+AW +: AW]     = src;
      p[ADDR_LSB+2*AW +: DW]   = data;
      return p;
   endfunction

   // upper bits random, ignored by the decode
   function automatic logic [AW-1:0] make_addr(input int bank, input int idx);
      logic [AW-1:0] a;
      a                      = $random(seed);
      a[1:0]                 = 2'b00;                // word aligned
      a[2 +: REGW]           = idx[REGW-1:0];
      a[2+REGW +: IDXW-REGW] = bank[IDXW-REGW-1:0];
      return a;
   endfunction

   // starts and ends at edge plus HOLD
   task automatic send_req(input logic [UW-1:0] pkt);
      logic acc;
      acc       = 1'b0;
      in_valid  = 1'b1;
      in_packet = pkt;
      while (!acc) begin
         acc = in_ready;  // registered, stable until the next edge
         @(posedge clk);
         #HOLD;
      end
      in_valid = 1'b0;
   endtask

   task automatic do_write(input logic [AW-1:0] addr, input logic [DW-1:0] data);
      model[addr[2 +: IDXW]] = data;
      send_req(make_packet(UMI_REQ_WRITE, 4'h2, addr, '0, data));
   endtask

   task automatic do_read(input logic [AW-1:0] addr);
      logic [TAGW-1:0] id;
      logic [3:0]      size;
      id           = next_tag;
      next_tag     = next_tag + 1'b1;
      size         = 4'($random(seed));
      exp_data[id] = model[addr[2 +: IDXW]];
      exp_size[id] = size;
      pending[id]  = 1'b1;
      outstanding++;
      reads_sent++;
      send_req(make_packet(UMI_REQ_READ, size, addr, TAG_BASE + AW'(id), DW'($random(seed))));
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (outstanding != 0 && n < DRAIN_LIMIT) begin
         @(posedge clk);
         #HOLD;
         n++;
      end
      assert (outstanding == 0) else report_problem("read responses missing after waiting");
   endtask

   task automatic finish_test(input string name, input int mark);
      int n;
      n = total_fails() - mark;
      if (n == 0) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d failed checks", name, n);
         tests_failed++;
      end
   endtask

   //####################################################################
   // host side, response monitor and out_ready
   //####################################################################

   // negedge sample, transfer happens at the next rising edge
   always @(negedge clk) begin : resp_monitor
      logic [AW-1:0]   dst;
      logic [TAGW-1:0] id;
      if (nreset && out_valid && out_ready) begin
         resp_count++;
         dst = out_packet[ADDR_LSB +: AW] - TAG_BASE;
         id  = dst[TAGW-1:0];
         if (dst >= MAX_TAGS || !pending[id]) begin
            report_problem("response tag was never sent or came back twice");
         end else begin
            assert (out_packet[ADDR_LSB+2*AW +: DW] == exp_data[id])
               else report_mismatch("out_packet.data", out_packet[ADDR_LSB+2*AW +: DW],
                                    exp_data[id]);
            assert (out_packet[SIZE_LSB +: SIZE_W] == exp_size[id])
               else report_mismatch("out_packet.size", DW'(out_packet[SIZE_LSB +: SIZE_W]),
                                    DW'(exp_size[id]));
            // responses carry a zero source address
            assert (out_packet[ADDR_LSB+AW +: AW] == '0)
               else report_mismatch("out_packet.srcaddr", DW'(out_packet[ADDR_LSB+AW +: AW]),
                                    DW'(0));
            pending[id] = 1'b0;
            outstanding--;
         end
      end
   end

   always @(posedge clk) begin
      #HOLD;
      out_ready = bp_on ? 1'($random(rdy_seed)) : 1'b1;
   end

   initial begin : watchdog
      #(TOTAL_OPS * 40 * PERIOD);
      $display("timeout, tests still running after %0d ns", TOTAL_OPS * 40 * PERIOD);
      $display("TEST FAIL");
      $finish;
   end

   //####################################################################
   // tests
   //####################################################################

   initial begin : main
      logic [AW-1:0] addr_q [$];
      logic [AW-1:0] a;
      logic [31:0]   r;
      int            mark;
      int            k;
      int            resp_mark;
      int            reads_mark;

      seed         = SEED;
      rdy_seed     = SEED + 32'd1;
      nreset       = 1'b0;
      in_valid     = 1'b0;
      in_packet    = '0;
      out_ready    = 1'b1;
      bp_on        = 1'b0;
      model        = '{default: '0};  // matches register reset
      pending      = '{default: 1'b0};
      next_tag     = '0;
      outstanding  = 0;
      reads_sent   = 0;
      resp_count   = 0;
      errors       = 0;
      tests_failed = 0;

      repeat (RST_CYC) @(posedge clk);
      #HOLD;
      nreset = 1'b1;

      // every register reads back zero
      mark = total_fails();
      for (int b = 0; b < NBANKS; b++) begin
         for (int i = 0; i < REGS; i++) begin
            do_read(make_addr(b, i));
         end
      end
      wait_drain();
      finish_test("reset state", mark);

      // batches of writes, then reads of the same addresses
      mark = total_fails();
      for (int rnd = 0; rnd < WR_ROUNDS; rnd++) begin
         for (int j = 0; j < WR_BATCH; j++) begin
            a = make_addr(j % NBANKS, $random(seed) & (REGS-1));
            r = $random(seed);
            do_write(a, r);
            addr_q.push_back(a);
         end
         while (addr_q.size() > 0) begin
            do_read(addr_q.pop_front());
         end
      end
      wait_drain();
      finish_test("write then read", mark);

      // idle system, out_valid three edges after accept
      mark = total_fails();
      do_read(make_addr(1, 3));
      k = 0;
      @(negedge clk);  // first negedge after the accept edge
      while (!out_valid && k < 20) begin
         @(negedge clk);
         k++;
      end
      assert (k == 3) else report_mismatch("out_valid delay in cycles", DW'(k), DW'(3));
      @(posedge clk);
      #HOLD;
      wait_drain();
      finish_test("idle read latency", mark);

      // back to back reads over all banks
      mark = total_fails();
      for (int rep = 0; rep < CONC_REPS; rep++) begin
         for (int b = 0; b < NBANKS; b++) begin
            do_read(make_addr(b, $random(seed) & (REGS-1)));
         end
      end
      wait_drain();
      finish_test("concurrent banks", mark);

      // mixed stream under random out_ready
      mark       = total_fails();
      resp_mark  = resp_count;
      reads_mark = reads_sent;
      bp_on      = 1'b1;
      for (int i = 0; i < BP_OPS; i++) begin
         r = $random(seed);
         a = make_addr(int'(r[5:4]), int'(r[2:0]));
         if (r[7:6] == 2'b00) begin
            do_write(a, DW'($random(seed)));
         end else begin
            do_read(a);
         end
      end
      wait_drain();
      bp_on = 1'b0;
      assert (resp_count - resp_mark == reads_sent - reads_mark)
         else report_mismatch("response count", DW'(resp_count - resp_mark),
                              DW'(reads_sent - reads_mark));
      finish_test("back-pressure", mark);

      $display("tests run 5, tests failed %0d, failed checks %0d", tests_failed, total_fails());
      if (total_fails() == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

//--- bench/umi_reg_subsys_chk.sv
`timescale 1ns/1ps

module umi_reg_subsys_chk #(
   parameter UW = 108
) (
   input logic          clk,
   input logic          nreset,
   input logic          in_ready,
   input logic          out_valid,
   input logic [UW-1:0] out_packet,
   input logic          out_ready
);

   import umi_reg_pkg::*;

   int unsigned fails = 0;  // failed assertions so far

   // stalled response holds valid and payload
   a_out_stable: assert property (@(posedge clk) disable iff (!nreset)
      out_valid && !out_ready |=> out_valid && $stable(out_packet))
      else begin
         $error("out_packet changed while out_ready was low");
         fails++;
      end

   a_rst_out_valid: assert property (@(posedge clk) !nreset |-> !out_valid)
      else begin
         $error("out_valid high during reset");
         fails++;
      end

   // subsystem only answers reads
   a_resp_cmd: assert property (@(posedge clk) disable iff (!nreset)
      out_valid |-> out_packet[CMD_LSB +: CMD_W] == UMI_RESP_READ)
      else begin
         $error("response command is not a read response");
         fails++;
      end

   a_rst_in_ready: assert property (@(posedge clk) !nreset |-> in_ready)
      else begin
         $error("in_ready low during reset");
         fails++;
      end

endmodule

//--- rtl/umi_reg_subsys.sv
`timescale 1ns/1ps

module umi_reg_subsys #(
   parameter  AW     = 32,
   parameter  DW     = 32,
   parameter  NBANKS = 4,
   parameter  REGS   = 8,
   localparam UW     = umi_reg_pkg::ADDR_LSB + 2*AW + DW  // full packet width
) (
   input  logic          clk,
   input  logic          nreset,
   // host requests
   input  logic          in_valid,
   input  logic [UW-1:0] in_packet,
   output logic          in_ready,
   // host responses
   output logic          out_valid,
   output logic [UW-1:0] out_packet,
   input  logic          out_ready
);

   import umi_reg_pkg::*;

   // dispatcher to banks
   logic [NBANKS-1:0]          req_valid;
   logic [NBANKS-1:0]          req_ready;
   logic                       req_write;
   logic [$clog2(REGS)-1:0]    req_index;
   logic [SIZE_W-1:0]          req_size;
   logic [AW-1:0]              req_srcaddr;
   logic [DW-1:0]              req_wrdata;

   // banks to merger, flattened
   logic [NBANKS-1:0]          resp_valid;
   logic [NBANKS-1:0]          resp_ready;
   logic [NBANKS*SIZE_W-1:0]   resp_size;
   logic [NBANKS*AW-1:0]       resp_dstaddr;
   logic [NBANKS*DW-1:0]       resp_data;

   umi_req_dispatch #(
      .AW(AW), .DW(DW), .NBANKS(NBANKS), .REGS(REGS), .UW(UW)
   ) u_dispatch (
      .clk         (clk),
      .nreset      (nreset),
      .in_valid    (in_valid),
      .in_packet   (in_packet),
      .in_ready    (in_ready),
      .req_valid   (req_valid),
      .req_ready   (req_ready),
      .req_write   (req_write),
      .req_index   (req_index),
      .req_size    (req_size),
      .req_srcaddr (req_srcaddr),
      .req_wrdata  (req_wrdata)
   );

   //####################################################################
   // banks, one slice of each response bus per bank
   //####################################################################

   for (genvar b = 0; b < NBANKS; b++) begin : g_bank
      umi_regbank #(
         .AW(AW), .DW(DW), .REGS(REGS)
      ) u_bank (
         .clk          (clk),
         .nreset       (nreset),
         .req_valid    (req_valid[b]),
         .req_ready    (req_ready[b]),
         .req_write    (req_write),
         .req_index    (req_index),
         .req_size     (req_size),
         .req_srcaddr  (req_srcaddr),
         .req_wrdata   (req_wrdata),
         .resp_valid   (resp_valid[b]),
         .resp_ready   (resp_ready[b]),
         .resp_size    (resp_size[b*SIZE_W +: SIZE_W]),
         .resp_dstaddr (resp_dstaddr[b*AW +: AW]),
         .resp_data    (resp_data[b*DW +: DW])
      );
   end

   umi_resp_merge #(
      .AW(AW), .DW(DW), .NBANKS(NBANKS), .UW(UW)
   ) u_merge (
      .clk          (clk),
      .nreset       (nreset),
      .resp_valid   (resp_valid),
      .resp_ready   (resp_ready),
      .resp_size    (resp_size),
      .resp_dstaddr (resp_dstaddr),
      .resp_data    (resp_data),
      .out_valid    (out_valid),
      .out_packet   (out_packet),
      .out_ready    (out_ready)
   );

endmodule

//--- rtl/umi_resp_merge.sv
`timescale 1ns/1ps

module umi_resp_merge #(
   parameter AW     = 32,
   parameter DW     = 32,
   parameter NBANKS = 4,
   parameter UW     = 108
) (
   input  logic                                    clk,
   input  logic                                    nreset,
   // flattened bank responses, bank b at slice b
   input  logic [NBANKS-1:0]                       resp_valid,
   output logic [NBANKS-1:0]                       resp_ready,
   input  logic [NBANKS*umi_reg_pkg::SIZE_W-1:0]   resp_size,
   input  logic [NBANKS*AW-1:0]                    resp_dstaddr,
   input  logic [NBANKS*DW-1:0]                    resp_data,
   // host response port
   output logic                                    out_valid,
   output logic [UW-1:0]                           out_packet,
   input  logic                                    out_ready
);

   import umi_reg_pkg::*;

   localparam BW = $clog2(NBANKS);

   logic              gnt_busy;   // a bank is granted, waiting for the output reg
   logic [BW-1:0]     gnt_idx;
   logic [BW-1:0]     last_win;   // rr pointer
   logic              load;       // output reg takes the granted bank
   logic [NBANKS-1:0] cand;       // banks eligible for the next grant
   logic              pick_found;
   logic [BW-1:0]     pick_idx;
   logic [UW-1:0]     pkt_next;

   assign load       = gnt_busy & (~out_valid | out_ready);
   assign resp_ready = load ? (NBANKS'(1) << gnt_idx) : '0;
   // bank being drained still shows valid this cycle, mask it
   assign cand       = resp_valid & ~resp_ready;

   //####################################################################
   // round-robin pick, search starts after the last winner
   //####################################################################

   always_comb begin : rr_pick
      logic [BW-1:0] scan;
      pick_found = 1'b0;
      pick_idx   = last_win;
      for (int i = 1; i <= NBANKS; i++) begin
         scan = last_win + BW'(i);  // wraps, NBANKS is a power of two
         if (!pick_found && cand[scan]) begin
            pick_found = 1'b1;
            pick_idx   = scan;
         end
      end
   end

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         gnt_busy <= 1'b0;
         gnt_idx  <= '0;
         last_win <= '0;
      end else if ((~gnt_busy | load) & pick_found) begin
         gnt_busy <= 1'b1;
         gnt_idx  <= pick_idx;
         last_win <= pick_idx;
      end else if (load) begin
         gnt_busy <= 1'b0;
      end
   end

   // pack granted bank, srcaddr stays zero
   always_comb begin
      pkt_next                           = '0;
      pkt_next[CMD_LSB +: CMD_W]         = UMI_RESP_READ;
      pkt_next[SIZE_LSB +: SIZE_W]       = resp_size[gnt_idx*SIZE_W +: SIZE_W];
      pkt_next[ADDR_LSB +: AW]           = resp_dstaddr[gnt_idx*AW +: AW];
      pkt_next[ADDR_LSB+2*AW +: DW]      = resp_data[gnt_idx*DW +: DW];
   end

   //####################################################################
   // output register, holds until host drains it
   //####################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         out_valid <= 1'b0;
      end else if (load) begin
         out_valid <= 1'b1;
      end else if (out_ready) begin
         out_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         out_packet <= pkt_next;
      end
   end

endmodule

//--- rtl/umi_regbank.sv
`timescale 1ns/1ps

module umi_regbank #(
   parameter AW   = 32,
   parameter DW   = 32,
   parameter REGS = 8
) (
   input  logic                             clk,
   input  logic                             nreset,
   // request from dispatcher
   input  logic                             req_valid,
   output logic                             req_ready,
   input  logic                             req_write,
   input  logic [$clog2(REGS)-1:0]          req_index,
   input  logic [umi_reg_pkg::SIZE_W-1:0]   req_size,
   input  logic [AW-1:0]                    req_srcaddr,
   input  logic [DW-1:0]                    req_wrdata,
   // response to merger
   output logic                             resp_valid,
   input  logic                             resp_ready,
   output logic [umi_reg_pkg::SIZE_W-1:0]   resp_size,
   output logic [AW-1:0]                    resp_dstaddr,
   output logic [DW-1:0]                    resp_data
);

   logic [DW-1:0] regs [REGS];  // register file
   logic          wr_en;
   logic          rd_en;
   logic          resp_done;    // merger took the response

   // single outstanding read, bank blocks until it is taken
   assign req_ready = ~resp_valid;

   assign wr_en     = req_valid & req_ready & req_write;
   assign rd_en     = req_valid & req_ready & ~req_write;
   assign resp_done = resp_valid & resp_ready;

   //####################################################################
   // register storage
   //####################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         for (int i = 0; i < REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[req_index] <= req_wrdata;  // full word, no masking
      end
   end

   //####################################################################
   // read response
   //####################################################################

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         resp_valid <= 1'b0;
      end else if (rd_en) begin
         resp_valid <= 1'b1;
      end else if (resp_done) begin
         resp_valid <= 1'b0;
      end
   end

   // capture answer at accept, held until drained
   always_ff @(posedge clk) begin
      if (rd_en) begin
         resp_size    <= req_size;          // echoed
         resp_dstaddr <= req_srcaddr;       // host tag goes back as dstaddr
         resp_data    <= regs[req_index];
      end
   end

endmodule

//--- rtl/umi_req_dispatch.sv
`timescale 1ns/1ps

module umi_req_dispatch #(
   parameter AW     = 32,
   parameter DW     = 32,
   parameter NBANKS = 4,
   parameter REGS   = 8,
   parameter UW     = 108
) (
   input  logic                             clk,
   input  logic                             nreset,
   // host request port
   input  logic                             in_valid,
   input  logic [UW-1:0]                    in_packet,
   output logic                             in_ready,
   // request bus, shared by all banks
   output logic [NBANKS-1:0]                req_valid,
   input  logic [NBANKS-1:0]                req_ready,
   output logic                             req_write,
   output logic [$clog2(REGS)-1:0]          req_index,
   output logic [umi_reg_pkg::SIZE_W-1:0]   req_size,
   output logic [AW-1:0]                    req_srcaddr,
   output logic [DW-1:0]                    req_wrdata
);

   import umi_reg_pkg::*;

   localparam REGW = $clog2(REGS);   // register index bits
   localparam BW   = $clog2(NBANKS); // bank select bits

   umi_cmd_t      in_cmd;
   logic [AW-1:0] in_dstaddr;
   logic [BW-1:0] in_bank;
   logic [BW-1:0] stage_bank;  // bank of the held request
   logic          busy;        // stage holds a request
   logic          drain;       // stage handed off this edge
   logic          take;        // new request captured this edge

   // unpack host fields
   assign in_cmd     = umi_cmd_t'(in_packet[CMD_LSB +: CMD_W]);
   assign in_dstaddr = in_packet[ADDR_LSB +: AW];
   // word addressed, bank sits right above the register index
   assign in_bank    = in_dstaddr[2+REGW +: BW];

   assign drain    = busy & req_ready[stage_bank];
   assign in_ready = ~busy | drain;  // refill on the same edge
   assign take     = in_valid & in_ready;

   // only the decoded bank sees valid
   assign req_valid = busy ? (NBANKS'(1) << stage_bank) : '0;

   always_ff @(posedge clk or negedge nreset) begin
      if (!nreset) begin
         busy <= 1'b0;
      end else if (take) begin
         busy <= 1'b1;
      end else if (drain) begin
         busy <= 1'b0;
      end
   end

   // one-entry stage payload
   always_ff @(posedge clk) begin
      if (take) begin
         stage_bank  <= in_bank;
         req_write   <= (in_cmd == UMI_REQ_WRITE);  // anything else reads
         req_index   <= in_dstaddr[2 +: REGW];
         req_size    <= in_packet[SIZE_LSB +: SIZE_W];
         req_srcaddr <= in_packet[ADDR_LSB+AW +: AW];    // becomes resp dstaddr
         req_wrdata  <= in_packet[ADDR_LSB+2*AW +: DW];
      end
   end

endmodule

//--- rtl/umi_reg_pkg.sv
package umi_reg_pkg;

   //####################################################################
   // packet commands
   //####################################################################

   // host sends the two request kinds, subsystem only ever answers reads
   typedef enum logic [7:0] {
      UMI_REQ_READ  = 8'h01,  // read request, answered
      UMI_REQ_WRITE = 8'h03,  // posted write, no answer
      UMI_RESP_READ = 8'h08   // read response back to host
   } umi_cmd_t;

   //####################################################################
   // packet layout, lsb first
   //####################################################################

   //  [7:0]                   command
   //  [11:8]                  size, echoed only
   //  [12 +: AW]              destination address
   //  [12+AW +: AW]           source address
   //  [12+2*AW +: DW]         data

   localparam int CMD_LSB  = 0;   // command field
   localparam int CMD_W    = 8;
   localparam int SIZE_LSB = 8;   // size field
   localparam int SIZE_W   = 4;
   localparam int ADDR_LSB = 12;  // dstaddr start, srcaddr and data follow

endpackage
